/* design/mci_params.svh */
/*
 * Build-time sizes for the management controller fault block
 * Watchdog width, aggregated error source count and pipeline depth
 */

`ifndef MCI_PARAMS_SVH
`define MCI_PARAMS_SVH

// Width of every watchdog count and period field
`define MCI_WDT_WIDTH 32

// Number of external error sources on each aggregated path
`define MCI_AGG_ERR_NUM 8

// Register stages between the masked sources and the all-error register.
// With 2 stages a source shows on all_error three cycles after it is seen
`define MCI_AGG_STAGES 2

`endif

/* design/mci_pkg.sv */
/*
 * Shared types for the fault block
 * Watchdog config, pulse and status structs, hw error structs, agg vector
 */

`include "mci_params.svh"

package mci_pkg;

  ////////////////////
  // Watchdog
  ////////////////////

  typedef logic [`MCI_WDT_WIDTH-1:0] wdt_count_t;

  typedef struct packed {
    logic       timer1_en;
    logic       timer2_en;
    wdt_count_t t1_period;
    wdt_count_t t2_period;
  } wdt_cfg_t;

  // One bit per timer, used for both pet and service requests
  typedef struct packed {
    logic t1;
    logic t2;
  } wdt_pulse_t;

  typedef struct packed {
    logic t1_timeout;
    logic t2_timeout;
  } wdt_status_t;

  ////////////////////
  // Error reporting
  ////////////////////

  typedef struct packed {
    logic nmi_pin;
    logic mcu_sram_ecc_unc;
    logic mcu_sram_dmi_axi_collision;
  } hw_err_fatal_t;

  typedef struct packed {
    logic mbox0_ecc_unc;
    logic mbox1_ecc_unc;
  } hw_err_non_fatal_t;

  typedef logic [`MCI_AGG_ERR_NUM-1:0] agg_err_t;

endpackage

/* design/mci_wdt_timer.sv */
/*
 * Single watchdog stage: up counter with pet, service and sticky timeout
 */

`timescale 1ns/1ps

module mci_wdt_timer
  import mci_pkg::*;
(
  input  logic       core_clk,
  input  logic       reset_i,
  input  logic       run_i,
  input  wdt_count_t period_i,
  input  logic       pet_i,
  input  logic       service_i,
  output wdt_count_t count_o,
  output logic       timeout_o
);

  wdt_count_t count_q;
  logic       timeout_q;
  logic       expired;

  assign expired = (count_q == period_i);

  // Service has the highest priority and also clears the flag.
  // Once the flag is set the count is frozen until a service
  always_ff @(posedge core_clk) begin
    if (reset_i) begin
      count_q   <= '0;
      timeout_q <= 1'b0;
    end else if (service_i) begin
      count_q   <= '0;
      timeout_q <= 1'b0;
    end else if (pet_i && !timeout_q) begin
      count_q <= '0;
    end else if (run_i && !timeout_q) begin
      if (expired) begin
        timeout_q <= 1'b1;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  assign count_o   = count_q;
  assign timeout_o = timeout_q;

  pet_restart_a: assert property (
    @(posedge core_clk) disable iff (reset_i)
    (pet_i && !timeout_o) |=> (count_o == '0)
  ) else $error("WDT timer did not restart on pet");

  service_restart_a: assert property (
    @(posedge core_clk) disable iff (reset_i)
    service_i |=> (count_o == '0)
  ) else $error("WDT timer did not restart after service");

endmodule

/* design/mci_wdt.sv */
/*
 * Two-stage watchdog with cascade and independent modes
 * NMI pulse on the rising edge of the second stage timeout
 */

`timescale 1ns/1ps

module mci_wdt
  import mci_pkg::*;
(
  input  logic        core_clk,
  input  logic        reset_i,
  input  wdt_cfg_t    cfg_i,
  input  wdt_pulse_t  pet_i,
  input  wdt_pulse_t  service_i,
  output wdt_status_t status_o,
  output logic        nmi_o
);

  logic t1_timeout;
  logic t2_timeout;
  logic t2_run;
  logic t2_timeout_q;

  // In cascade mode the second stage only counts while the first has expired
  assign t2_run = cfg_i.timer2_en ? 1'b1 : t1_timeout;

  mci_wdt_timer u_timer1 (
    .core_clk  (core_clk),
    .reset_i   (reset_i),
    .run_i     (cfg_i.timer1_en),
    .period_i  (cfg_i.t1_period),
    .pet_i     (pet_i.t1),
    .service_i (service_i.t1),
    .count_o   (),
    .timeout_o (t1_timeout)
  );

  mci_wdt_timer u_timer2 (
    .core_clk  (core_clk),
    .reset_i   (reset_i),
    .run_i     (t2_run),
    .period_i  (cfg_i.t2_period),
    .pet_i     (pet_i.t2),
    .service_i (service_i.t2),
    .count_o   (),
    .timeout_o (t2_timeout)
  );

  ////////////////////
  // NMI edge detect
  ////////////////////

  always_ff @(posedge core_clk) begin
    if (reset_i) begin
      t2_timeout_q <= 1'b0;
    end else begin
      t2_timeout_q <= t2_timeout;
    end
  end

  // High only in the first cycle of a new second stage expiry
  assign nmi_o = t2_timeout & ~t2_timeout_q;

  assign status_o.t1_timeout = t1_timeout;
  assign status_o.t2_timeout = t2_timeout;

  nmi_single_pulse_a: assert property (
    @(posedge core_clk) disable iff (reset_i)
    nmi_o |=> !nmi_o
  ) else $error("NMI held high for more than one cycle");

endmodule

/* design/mci_err_capture.sv */
/*
 * Sticky hardware error register with write-one-to-clear
 * Per-bit mask on the any-error reduction, shared by fatal and non-fatal
 */

`timescale 1ns/1ps

module mci_err_capture
  import mci_pkg::*;
#(
  parameter type err_t = hw_err_fatal_t
) (
  input  logic core_clk,
  input  logic reset_i,
  input  err_t event_i,
  input  err_t mask_i,
  input  err_t clear_i,
  output err_t err_o,
  output logic any_o
);

  err_t err_q;

  // A new event beats a clear of the same bit in the same cycle
  always_ff @(posedge core_clk) begin
    if (reset_i) begin
      err_q <= '0;
    end else begin
      err_q <= (err_q & ~clear_i) | event_i;
    end
  end

  assign err_o = err_q;

  // Mask bit 1 hides the error from the aggregated output only
  assign any_o = |(err_q & ~mask_i);

  event_captured_a: assert property (
    @(posedge core_clk) disable iff (reset_i)
    (|event_i) |=> ((err_o & $past(event_i)) == $past(event_i))
  ) else $error("Error event not captured in the sticky register");

endmodule

/* design/mci_err_agg.sv */
/*
 * Aggregated error path: mask, OR-reduce, pipeline, then combine
 * with the sticky hw error summary into one registered all-error output
 */

`timescale 1ns/1ps

`include "mci_params.svh"

module mci_err_agg
  import mci_pkg::*;
(
  input  logic     core_clk,
  input  logic     reset_i,
  input  agg_err_t src_i,
  input  agg_err_t mask_i,
  input  logic     hw_any_i,
  output logic     all_error_o
);

  agg_err_t                   src_masked;
  logic [`MCI_AGG_STAGES-1:0] stage_q;
  logic                       all_error_q;

  assign src_masked = src_i & ~mask_i;

  ////////////////////
  // Pipeline
  ////////////////////

  // Sources are reduced before the first stage, so every stage is one bit
  always_ff @(posedge core_clk) begin
    if (reset_i) begin
      stage_q <= '0;
    end else begin
      stage_q[0] <= |src_masked;
      for (int i = 1; i < `MCI_AGG_STAGES; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // Sticky hw errors skip the pipeline and land here directly
  always_ff @(posedge core_clk) begin
    if (reset_i) begin
      all_error_q <= 1'b0;
    end else begin
      all_error_q <= stage_q[`MCI_AGG_STAGES-1] | hw_any_i;
    end
  end

  assign all_error_o = all_error_q;

  agg_latency_a: assert property (
    @(posedge core_clk) disable iff (reset_i)
    (|src_masked) |-> ##3 all_error_o
  ) else $error("Unmasked aggregated error did not reach all_error on time");

endmodule

/* design/mci_top.sv */
/*
 * Fault block top: watchdog, fatal and non-fatal sticky registers,
 * and the two all-error aggregators
 */

`timescale 1ns/1ps

module mci_top
  import mci_pkg::*;
(
  input  logic              core_clk,
  input  logic              reset_i,
  input  wdt_cfg_t          wdt_cfg_i,
  input  wdt_pulse_t        wdt_pet_i,
  input  wdt_pulse_t        wdt_service_i,
  output wdt_status_t       wdt_status_o,
  input  logic              sram_ecc_unc_i,
  input  logic              sram_dmi_axi_collision_i,
  input  hw_err_non_fatal_t hw_err_non_fatal_i,
  input  hw_err_fatal_t     fatal_mask_i,
  input  hw_err_fatal_t     fatal_clear_i,
  input  hw_err_non_fatal_t non_fatal_mask_i,
  input  hw_err_non_fatal_t non_fatal_clear_i,
  input  agg_err_t          agg_err_i,
  input  agg_err_t          agg_fatal_mask_i,
  input  agg_err_t          agg_non_fatal_mask_i,
  output hw_err_fatal_t     hw_err_fatal_o,
  output hw_err_non_fatal_t hw_err_non_fatal_o,
  output logic              all_error_fatal_o,
  output logic              all_error_non_fatal_o
);

  logic          nmi;
  hw_err_fatal_t fatal_event;
  logic          fatal_any;
  logic          non_fatal_any;

  mci_wdt u_wdt (
    .core_clk  (core_clk),
    .reset_i   (reset_i),
    .cfg_i     (wdt_cfg_i),
    .pet_i     (wdt_pet_i),
    .service_i (wdt_service_i),
    .status_o  (wdt_status_o),
    .nmi_o     (nmi)
  );

  ////////////////////
  // Sticky hw errors
  ////////////////////

  assign fatal_event.nmi_pin                    = nmi;
  assign fatal_event.mcu_sram_ecc_unc           = sram_ecc_unc_i;
  assign fatal_event.mcu_sram_dmi_axi_collision = sram_dmi_axi_collision_i;

  mci_err_capture #(.err_t(hw_err_fatal_t)) u_fatal_cap (
    .core_clk (core_clk),
    .reset_i  (reset_i),
    .event_i  (fatal_event),
    .mask_i   (fatal_mask_i),
    .clear_i  (fatal_clear_i),
    .err_o    (hw_err_fatal_o),
    .any_o    (fatal_any)
  );

  mci_err_capture #(.err_t(hw_err_non_fatal_t)) u_non_fatal_cap (
    .core_clk (core_clk),
    .reset_i  (reset_i),
    .event_i  (hw_err_non_fatal_i),
    .mask_i   (non_fatal_mask_i),
    .clear_i  (non_fatal_clear_i),
    .err_o    (hw_err_non_fatal_o),
    .any_o    (non_fatal_any)
  );

  // Both aggregators see the same sources, each through its own mask
  mci_err_agg u_fatal_agg (
    .core_clk    (core_clk),
    .reset_i     (reset_i),
    .src_i       (agg_err_i),
    .mask_i      (agg_fatal_mask_i),
    .hw_any_i    (fatal_any),
    .all_error_o (all_error_fatal_o)
  );

  mci_err_agg u_non_fatal_agg (
    .core_clk    (core_clk),
    .reset_i     (reset_i),
    .src_i       (agg_err_i),
    .mask_i      (agg_non_fatal_mask_i),
    .hw_any_i    (non_fatal_any),
    .all_error_o (all_error_non_fatal_o)
  );

endmodule

/* dv/mci_tb.sv */
/*
 * Testbench for the fault block top level
 * Runs one test per line of the stimulus file and reports the counts
 */

`timescale 1ns/1ps

module mci_tb
  import mci_pkg::*;
();

  logic              core_clk;
  logic              reset_i;
  wdt_cfg_t          wdt_cfg_i;
  wdt_pulse_t        wdt_pet_i;
  wdt_pulse_t        wdt_service_i;
  wdt_status_t       wdt_status_o;
  logic              sram_ecc_unc_i;
  logic              sram_dmi_axi_collision_i;
  hw_err_non_fatal_t hw_err_non_fatal_i;
  hw_err_fatal_t     fatal_mask_i;
  hw_err_fatal_t     fatal_clear_i;
  hw_err_non_fatal_t non_fatal_mask_i;
  hw_err_non_fatal_t non_fatal_clear_i;
  agg_err_t          agg_err_i;
  agg_err_t          agg_fatal_mask_i;
  agg_err_t          agg_non_fatal_mask_i;
  hw_err_fatal_t     hw_err_fatal_o;
  hw_err_non_fatal_t hw_err_non_fatal_o;
  logic              all_error_fatal_o;
  logic              all_error_non_fatal_o;

  // Columns of the current stimulus line
  logic [31:0]      kind;
  logic [31:0]      a;
  logic [31:0]      b;
  logic [31:0]      c;
  logic [31:0]      d;
  logic [31:0]      exp_v;
  logic [8*256-1:0] line;
  logic [1:0]       expect_q[$];
  logic [31:0]      rng = 32'h5dc;
  string            test_name;
  string            kind_names[7] = '{"", "cascade", "independent", "pet-service",
                                      "sticky", "aggregation", "reset"};
  int               fd;
  int               limit = 0;
  int               cycles = 0;
  int               tests = 0;
  int               failed = 0;
  int               errs = 0;
  int               test_errs = 0;

  mci_top uut (.*);

  initial begin
    core_clk = 1'b0;
    forever #50 core_clk = ~core_clk;
  end

  always @(posedge core_clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: the run went past its limit of %0d cycles", limit);
      $display("Checks failed");
      $finish;
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // A source counts when its bit is set and its mask bit is clear
  function automatic logic any_unmasked(input agg_err_t src, input agg_err_t mask);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < $bits(agg_err_t); i++) begin
      if (src[i] && !mask[i]) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // Inputs change 1 ns after the edge and outputs are read at the same point
  task automatic tick(input int n);
    repeat (n) @(posedge core_clk);
    #1;
  endtask

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s, %s: expected %0h, actual %0h", test_name, what, expected, actual);
      test_errs++;
    end
  endtask

  task automatic reset_dut(input int n);
    reset_i                  = 1'b1;
    wdt_cfg_i                = '0;
    wdt_pet_i                = '0;
    wdt_service_i            = '0;
    sram_ecc_unc_i           = 1'b0;
    sram_dmi_axi_collision_i = 1'b0;
    hw_err_non_fatal_i       = '0;
    fatal_mask_i             = '0;
    fatal_clear_i            = '0;
    non_fatal_mask_i         = '0;
    non_fatal_clear_i        = '0;
    agg_err_i                = '0;
    agg_fatal_mask_i         = '0;
    agg_non_fatal_mask_i     = '0;
    tick(n);
    reset_i = 1'b0;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic run_test();
    reset_dut(2);
    tests++;
    test_errs = 0;
    test_name = $sformatf("%0d:%s", tests, (kind <= 6) ? kind_names[kind] : "unknown");
    case (kind)
      1: begin
        wdt_cfg_i = '{timer1_en: 1'b1, timer2_en: 1'b0, t1_period: a, t2_period: b};
        wdt_pet_i.t1 = 1'b1;
        tick(1);
        wdt_pet_i.t1 = 1'b0;
        tick(a);
        check("t1 low at pet+1+period", 0, wdt_status_o.t1_timeout);
        tick(1);
        check("t1 high at pet+2+period", 1, wdt_status_o.t1_timeout);
        tick(b);
        check("t2 low before its period", 0, wdt_status_o.t2_timeout);
        tick(1);
        check("t2 high after its period", 1, wdt_status_o.t2_timeout);
        check("nmi not captured yet", 0, hw_err_fatal_o);
        tick(1);
        check("nmi_pin captured", exp_v, hw_err_fatal_o);
      end
      2: begin
        wdt_cfg_i = '{timer1_en: 1'b1, timer2_en: 1'b1, t1_period: a, t2_period: b};
        for (int n = 1; n <= b + 1; n++) begin
          tick(1);
          check("t1 held low by pets", 0, wdt_status_o.t1_timeout);
          if (n == b) begin
            check("t2 low before its period", 0, wdt_status_o.t2_timeout);
          end
          wdt_pet_i.t1 = (n % c == 0);
        end
        check("status at t2 expiry", exp_v, wdt_status_o);
      end
      3: begin
        // Timer 2 runs on its own with a period far beyond the test
        wdt_cfg_i = '{timer1_en: 1'b1, timer2_en: 1'b1, t1_period: a, t2_period: '1};
        wdt_pet_i.t1 = 1'b1;
        tick(1);
        wdt_pet_i.t1 = 1'b0;
        repeat (c) begin
          tick(a - 2);
          check("t1 low before pet", 0, wdt_status_o.t1_timeout);
          wdt_pet_i.t1 = 1'b1;
          tick(1);
          wdt_pet_i.t1 = 1'b0;
        end
        tick(a);
        check("t1 low one period after last pet", 0, wdt_status_o.t1_timeout);
        tick(1);
        check("t1 high without pets", 1, wdt_status_o.t1_timeout);
        wdt_pet_i.t1 = 1'b1;
        tick(1);
        wdt_pet_i.t1 = 1'b0;
        check("pet ignored while timed out", 1, wdt_status_o.t1_timeout);
        wdt_service_i.t1 = 1'b1;
        tick(1);
        wdt_service_i.t1 = 1'b0;
        check("t1 cleared by service", 0, wdt_status_o.t1_timeout);
        tick(a);
        check("t1 low one period after service", 0, wdt_status_o.t1_timeout);
        tick(1);
        check("status after second expiry", exp_v, wdt_status_o);
      end
      4: begin
        fatal_mask_i = c[2:0];
        non_fatal_mask_i = d[1:0];
        {sram_ecc_unc_i, sram_dmi_axi_collision_i} = a[1:0];
        hw_err_non_fatal_i = b[1:0];
        tick(1);
        {sram_ecc_unc_i, sram_dmi_axi_collision_i} = 2'b00;
        hw_err_non_fatal_i = '0;
        check("fatal bits set", a[1:0], hw_err_fatal_o);
        check("non-fatal bits set", b[1:0], hw_err_non_fatal_o);
        check("all-error one cycle on", 0, {all_error_fatal_o, all_error_non_fatal_o});
        tick(1);
        check("all-error two cycles on", exp_v, {all_error_fatal_o, all_error_non_fatal_o});
        tick(4);
        check("fatal bits sticky", a[1:0], hw_err_fatal_o);
        check("non-fatal bits sticky", b[1:0], hw_err_non_fatal_o);
        fatal_clear_i = '1;
        non_fatal_clear_i = '1;
        tick(1);
        fatal_clear_i = '0;
        non_fatal_clear_i = '0;
        check("fatal bits cleared", 0, hw_err_fatal_o);
        check("non-fatal bits cleared", 0, hw_err_non_fatal_o);
        tick(1);
        check("all-error after clear", 0, {all_error_fatal_o, all_error_non_fatal_o});
      end
      5: begin
        agg_fatal_mask_i = c[7:0];
        agg_non_fatal_mask_i = d[7:0];
        expect_q.delete();
        for (int n = 0; n < a + 3; n++) begin
          if (n >= 3) begin
            check("all-error pair", expect_q.pop_front(),
                  {all_error_fatal_o, all_error_non_fatal_o});
          end
          rng = xorshift(rng);
          agg_err_i = (n < a) ? rng[7:0] : '0;
          // Any source left unmasked shows three cycles later
          expect_q.push_back({any_unmasked(agg_err_i, agg_fatal_mask_i),
                              any_unmasked(agg_err_i, agg_non_fatal_mask_i)});
          tick(1);
        end
        check("all-error after drain", exp_v, {all_error_fatal_o, all_error_non_fatal_o});
      end
      6: begin
        wdt_cfg_i = '{timer1_en: 1'b1, timer2_en: 1'b1, t1_period: 1, t2_period: 1};
        {sram_ecc_unc_i, sram_dmi_axi_collision_i} = 2'b11;
        hw_err_non_fatal_i = '1;
        agg_err_i = '1;
        tick(4);
        reset_dut(2);
        check("state after reset", exp_v, {wdt_status_o, hw_err_fatal_o, hw_err_non_fatal_o,
                                           all_error_fatal_o, all_error_non_fatal_o});
      end
      default: begin
        $display("Unknown test kind %0d in the stimulus file", kind);
        test_errs++;
      end
    endcase
    errs += test_errs;
    if (test_errs == 0) begin
      $display("Test %s: ok", test_name);
    end else begin
      failed++;
      $display("Test %s: %0d mismatches", test_name, test_errs);
    end
  endtask

  initial begin
    fd = $fopen("dv/mci_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file dv/mci_stim.txt");
      $display("Checks failed");
      $finish;
    end else begin
      // First pass sizes the cycle limit
      while ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "%h %h %h %h %h %h", kind, a, b, c, d, exp_v) == 6) begin
          limit = limit + 40 + ((kind <= 3) ? a + b : 0);
        end
      end
      $fclose(fd);
      reset_dut(16);
      fd = $fopen("dv/mci_stim.txt", "r");
      while ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "%h %h %h %h %h %h", kind, a, b, c, d, exp_v) == 6) begin
          run_test();
        end
      end
      $fclose(fd);
      $display("Tests run %0d, tests with errors %0d, mismatches %0d", tests, failed, errs);
      if (failed == 0 && tests > 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
      $finish;
    end
  end

endmodule

/* dv/mci_stim.txt */
# Columns, all hex: kind a b c d exp
# kind 1 cascade: a t1 period, b t2 period, exp fatal register after the NMI
# kind 2 independent: a t1 period, b t2 period, c pet interval, exp status at t2 expiry
# kind 3 pet and service: a t1 period, c pet count, exp status after the second expiry
# kind 4 sticky: a sram events, b mbox events, c fatal mask, d non-fatal mask
#        exp is {all_error_fatal, all_error_non_fatal} two cycles after the events
# kind 5 aggregation: a random samples, c fatal agg mask, d non-fatal agg mask, exp drained
# kind 6 reset: exp is the packed state after reset
1 0a 06 0 0 4
1 14 03 0 0 4
2 0f 19 0d 0 1
2 08 1e 06 0 1
3 0c 0 3 0 2
3 06 0 5 0 2
4 3 0 0 0 2
4 2 1 2 0 1
4 1 3 0 3 2
4 0 2 7 1 1
4 3 3 3 3 0
5 18 0 0f f0 0
5 14 0 00 ff 0
5 10 0 ff ff 0
6 0 0 0 0 0

/* all.f */
+incdir+design
design/mci_pkg.sv
design/mci_wdt_timer.sv
design/mci_wdt.sv
design/mci_err_capture.sv
design/mci_err_agg.sv
design/mci_top.sv
dv/mci_tb.sv

/* Makefile */
# Verilator build and run for the fault block testbench

VERILATOR ?= verilator
TOP       ?= mci_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= All checks passed

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
